//--- hdl/exec_pkg.sv
/*
 * Shared types and codes for the execute stage.
 * Holds widths, functional-unit and micro-op encodings, the RNG bus
 * payloads and the stage structs. Files refer to it with exec_pkg:: names.
 */
package exec_pkg;

    localparam int unsigned XLEN = 32;                  // Data width

    typedef logic [XLEN-1:0] xlen_t;                    // Data word
    typedef logic [4:0]      reg_addr_t;                // Register address
    typedef logic [4:0]      uop_t;                     // Micro-op code

    typedef enum logic [2:0] {
        FU_ALU = 3'd0,                                  // Integer ALU
        FU_LSU = 3'd1,                                  // Load/store
        FU_CFU = 3'd2,                                  // Branches and jumps
        FU_CSR = 3'd3,                                  // CSR access
        FU_RNG = 3'd4                                   // Random-number interface
    } fu_e;

    // ALU micro-ops ------------------------------------
    localparam uop_t ALU_ADD  = 5'd0;
    localparam uop_t ALU_SUB  = 5'd1;
    localparam uop_t ALU_XOR  = 5'd2;
    localparam uop_t ALU_OR   = 5'd3;
    localparam uop_t ALU_AND  = 5'd4;
    localparam uop_t ALU_SLL  = 5'd5;
    localparam uop_t ALU_SRL  = 5'd6;
    localparam uop_t ALU_SRA  = 5'd7;
    localparam uop_t ALU_SLT  = 5'd8;
    localparam uop_t ALU_SLTU = 5'd9;

    // Branch micro-ops ---------------------------------
    // Bits 4:3 give the class: 00 conditional, 01 resolved, 10 jump
    localparam uop_t CFU_BEQ       = 5'b00_001;
    localparam uop_t CFU_BNE       = 5'b00_010;
    localparam uop_t CFU_BLT       = 5'b00_011;
    localparam uop_t CFU_BGE       = 5'b00_100;
    localparam uop_t CFU_BLTU      = 5'b00_101;
    localparam uop_t CFU_BGEU      = 5'b00_110;
    localparam uop_t CFU_NOT_TAKEN = 5'b01_000;
    localparam uop_t CFU_TAKEN     = 5'b01_001;
    localparam uop_t CFU_JAL       = 5'b10_000;
    localparam uop_t CFU_JALR      = 5'b10_001;

    localparam int unsigned LSU_LOAD_BIT  = 3;          // Load flag in uop
    localparam int unsigned LSU_STORE_BIT = 4;          // Store flag in uop

    localparam uop_t RNG_TEST = 5'd1;                   // Query RNG health
    localparam uop_t RNG_SEED = 5'd2;                   // Push seed from rs1
    localparam uop_t RNG_SAMP = 5'd3;                   // Take one sample

    typedef enum logic [2:0] {
        RNG_OP_TEST = 3'd1,
        RNG_OP_SEED = 3'd2,
        RNG_OP_SAMP = 3'd4
    } rng_op_e;

    typedef logic [2:0] rng_status_t;                   // Raw RNG status

    // Stage payloads -----------------------------------
    typedef struct packed {
        reg_addr_t rd;                                  // Destination / trap cause
        fu_e       fu;
        uop_t      uop;
        xlen_t     opr_a;
        xlen_t     opr_b;
        xlen_t     opr_c;                               // Store data, jump target
        logic      trap;                                // Trap raised upstream
        logic [1:0] size;                               // Instruction size
    } s2_instr_t;

    typedef struct packed {
        reg_addr_t rd;
        fu_e       fu;
        uop_t      uop;
        logic      trap;
        logic [1:0] size;
    } s3_ctrl_t;

    typedef struct packed {
        rng_op_e op;
        xlen_t   data;                                  // Seed data
    } rng_req_t;

    typedef struct packed {
        rng_status_t status;
        xlen_t       data;                              // Sample data
    } rng_rsp_t;

endpackage

//--- hdl/exec_alu.sv
/*
 * Integer ALU of the execute stage, purely combinational.
 * Besides the ALU result it always gives the operand sum and the
 * compare flags, which branches and load/store reuse.
 */
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::uop_t  i_uop,                      // ALU micro-op
    input  exec_pkg::xlen_t i_lhs,                      // Operand A
    input  exec_pkg::xlen_t i_rhs,                      // Operand B
    input  logic            i_cmp_unsigned,             // Unsigned compare
    output exec_pkg::xlen_t o_result,                   // ALU result
    output exec_pkg::xlen_t o_add_result,               // Always lhs + rhs
    output logic            o_lt,                       // lhs < rhs
    output logic            o_eq                        // lhs == rhs
);

    logic [4:0]      shamt;
    exec_pkg::xlen_t sum;
    exec_pkg::xlen_t diff;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt = i_rhs[4:0];                          // Low 5 bits only
    assign sum   = i_lhs + i_rhs;
    assign diff  = i_lhs - i_rhs;

    // Compare flags ------------------------------------
    assign lt_signed   = $signed(i_lhs) < $signed(i_rhs);
    assign lt_unsigned = i_lhs < i_rhs;

    assign o_lt = i_cmp_unsigned ? lt_unsigned : lt_signed;
    assign o_eq = i_lhs == i_rhs;

    assign o_add_result = sum;                          // Address and JALR target

    // Result mux ---------------------------------------
    always_comb begin
        unique case (i_uop)
            exec_pkg::ALU_ADD:  o_result = sum;
            exec_pkg::ALU_SUB:  o_result = diff;
            exec_pkg::ALU_XOR:  o_result = i_lhs ^ i_rhs;
            exec_pkg::ALU_OR:   o_result = i_lhs | i_rhs;
            exec_pkg::ALU_AND:  o_result = i_lhs & i_rhs;
            exec_pkg::ALU_SLL:  o_result = i_lhs << shamt;
            exec_pkg::ALU_SRL:  o_result = i_lhs >> shamt;
            exec_pkg::ALU_SRA:  o_result = exec_pkg::xlen_t'($signed(i_lhs) >>> shamt);
            exec_pkg::ALU_SLT,
            exec_pkg::ALU_SLTU: o_result = exec_pkg::xlen_t'(o_lt); // Flag picks sign
            default:            o_result = '0;          // Non-ALU uops
        endcase
    end

endmodule

//--- hdl/exec_result_select.sv
/*
 * Per-unit result selection for the execute stage.
 * Resolves branches, forms load/store, CSR and trap results and merges
 * them into the control word and the two operands for the next stage.
 */
`timescale 1ns/1ps

module exec_result_select (
    input  exec_pkg::s2_instr_t i_s2,                   // Instruction in execute
    input  exec_pkg::xlen_t     i_alu_result,           // ALU result
    input  exec_pkg::xlen_t     i_add_result,           // opr_a + opr_b
    input  logic                i_lt,                   // Compare flags
    input  logic                i_eq,
    input  exec_pkg::xlen_t     i_rng_result,           // RNG controller result
    output exec_pkg::s3_ctrl_t  o_ctrl,                 // Next-stage control
    output exec_pkg::xlen_t     o_opr_a,
    output exec_pkg::xlen_t     o_opr_b,
    output logic                o_opr_b_load            // Operand B is written
);

    logic            fu_lsu;
    logic            fu_cfu;
    logic            fu_csr;
    logic            lsu_store;
    logic            cfu_cond;
    logic            cfu_taken;
    exec_pkg::xlen_t cfu_target;

    assign fu_lsu = i_s2.fu == exec_pkg::FU_LSU;
    assign fu_cfu = i_s2.fu == exec_pkg::FU_CFU;
    assign fu_csr = i_s2.fu == exec_pkg::FU_CSR;

    assign lsu_store = fu_lsu && i_s2.uop[exec_pkg::LSU_STORE_BIT];

    // Branch resolution --------------------------------
    assign cfu_cond = fu_cfu && i_s2.uop[4:3] == 2'b00; // Conditional class

    always_comb begin
        unique case (i_s2.uop)
            exec_pkg::CFU_BEQ:  cfu_taken =  i_eq;
            exec_pkg::CFU_BNE:  cfu_taken = !i_eq;
            exec_pkg::CFU_BLT,
            exec_pkg::CFU_BLTU: cfu_taken =  i_lt;     // Sign set by caller
            exec_pkg::CFU_BGE,
            exec_pkg::CFU_BGEU: cfu_taken = !i_lt;
            default:            cfu_taken = 1'b0;
        endcase
    end

    assign cfu_target = i_s2.uop == exec_pkg::CFU_JALR ?
                        {i_add_result[exec_pkg::XLEN-1:1], 1'b0} :
                        {i_s2.opr_c[exec_pkg::XLEN-1:1], 1'b0};

    // Control word -------------------------------------
    assign o_ctrl.rd   = i_s2.rd;
    assign o_ctrl.fu   = i_s2.fu;
    assign o_ctrl.uop  = !cfu_cond ? i_s2.uop :
                         cfu_taken ? exec_pkg::CFU_TAKEN : exec_pkg::CFU_NOT_TAKEN;
    assign o_ctrl.trap = i_s2.trap;
    assign o_ctrl.size = i_s2.size;

    // Operand merge ------------------------------------
    always_comb begin
        unique case (i_s2.fu)
            exec_pkg::FU_ALU: o_opr_a = i_alu_result;
            exec_pkg::FU_LSU: o_opr_a = i_add_result;   // Effective address
            exec_pkg::FU_CFU: o_opr_a = cfu_target;
            exec_pkg::FU_CSR: o_opr_a = i_s2.opr_a;
            exec_pkg::FU_RNG: o_opr_a = i_rng_result;
            default:          o_opr_a = '0;
        endcase
    end

    // Trap cause wins over store data and CSR write data
    assign o_opr_b = i_s2.trap           ? exec_pkg::xlen_t'(i_s2.rd) :
                     lsu_store || fu_csr ? i_s2.opr_c : '0;

    assign o_opr_b_load = lsu_store || fu_csr || i_s2.trap;

endmodule

//--- hdl/exec_rng_if.sv
/*
 * Controller for the external random-number generator.
 * Sends one request per RNG instruction, collects the response and
 * keeps the result until the stage moves the instruction on.
 */
`timescale 1ns/1ps

module exec_rng_if (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               i_flush,                 // Back to idle
    input  logic               i_start,                 // RNG instruction present
    input  logic               i_progress,              // Stage hands it on
    input  exec_pkg::uop_t     i_uop,
    input  exec_pkg::xlen_t    i_rs1,                   // Seed data
    output exec_pkg::rng_req_t o_rng_req,
    output logic               o_rng_req_valid,
    input  logic               i_rng_req_ready,
    input  exec_pkg::rng_rsp_t i_rng_rsp,
    input  logic               i_rng_rsp_valid,
    output logic               o_rng_rsp_ready,
    output exec_pkg::xlen_t    o_result,                // Value for opr_a
    output logic               o_ready                  // Result available
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RSP, ST_DONE} state_e;

    state_e          state;
    exec_pkg::xlen_t result_q;

    // FSM ----------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            state <= ST_IDLE;
        end else begin
            unique case (state)
                ST_IDLE: if (i_start)         state <= ST_REQ;
                ST_REQ:  if (i_rng_req_ready) state <= ST_RSP;
                ST_RSP:  if (i_rng_rsp_valid) state <= ST_DONE;
                ST_DONE: if (i_progress)      state <= ST_IDLE;
                default:                      state <= ST_IDLE;
            endcase
        end
    end

    // Result captured on the response handshake
    always_ff @(posedge g_clk) begin
        if (o_rng_rsp_ready && i_rng_rsp_valid) begin
            result_q <= i_uop == exec_pkg::RNG_SAMP ? i_rng_rsp.data :
                        exec_pkg::xlen_t'(i_rng_rsp.status);
        end
    end

    // Request op from the uop, held stable by the issue side
    always_comb begin
        unique case (i_uop)
            exec_pkg::RNG_SEED: o_rng_req.op = exec_pkg::RNG_OP_SEED;
            exec_pkg::RNG_SAMP: o_rng_req.op = exec_pkg::RNG_OP_SAMP;
            default:            o_rng_req.op = exec_pkg::RNG_OP_TEST;
        endcase
    end

    assign o_rng_req.data  = i_rs1;
    assign o_rng_req_valid = state == ST_REQ;
    assign o_rng_rsp_ready = state == ST_RSP;
    assign o_ready         = state == ST_DONE;
    assign o_result        = result_q;

    // Request and its payload stay up until the RNG takes it
    a_req_held : assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_rng_req_valid && !i_rng_req_ready && !i_flush |=>
        o_rng_req_valid && $stable(o_rng_req));

endmodule

//--- hdl/exec_stage_reg.sv
/*
 * Stage register with valid/busy handshake and flush.
 * The payload type is a parameter, so one module carries both the
 * control struct and the data operands.
 */
`timescale 1ns/1ps

module exec_stage_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     i_flush,                           // Drop the content
    input  logic     i_load,                            // Capture i_data
    input  PAYLOAD_T i_data,
    input  logic     i_busy,                            // Downstream holds us
    output PAYLOAD_T o_data,
    output logic     o_valid
);

    PAYLOAD_T data_q;
    logic     valid_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_busy) begin
            valid_q <= i_load;                          // Drains with no load
        end
    end

    // Payload only moves on a load
    always_ff @(posedge g_clk) begin
        if (i_load && !i_busy) begin
            data_q <= i_data;
        end
    end

    assign o_data  = data_q;
    assign o_valid = valid_q;

    a_hold_stable : assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_busy |=> $stable(o_data));

endmodule

//--- hdl/exec_stage.sv
/*
 * Top level of the execute stage.
 * Runs the ALU, branch, load/store, CSR and RNG jobs on one issued
 * instruction and registers the result towards the next stage.
 */
`timescale 1ns/1ps

module exec_stage (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                i_flush,
    input  exec_pkg::s2_instr_t i_s2,                   // From issue
    input  logic                i_s2_valid,
    output logic                o_s2_busy,
    output exec_pkg::rng_req_t  o_rng_req,              // To RNG
    output logic                o_rng_req_valid,
    input  logic                i_rng_req_ready,
    input  exec_pkg::rng_rsp_t  i_rng_rsp,
    input  logic                i_rng_rsp_valid,
    output logic                o_rng_rsp_ready,
    output exec_pkg::s3_ctrl_t  o_s3_ctrl,              // To next stage
    output exec_pkg::xlen_t     o_s3_opr_a,
    output exec_pkg::xlen_t     o_s3_opr_b,
    output logic                o_s3_valid,
    input  logic                i_s3_busy
);

    logic               rng_valid, rng_ready, cmp_unsigned;
    logic               s3_hold, progress, lt, eq, opr_b_load;
    exec_pkg::xlen_t    alu_result, add_result, rng_result, n_opr_a, n_opr_b;
    exec_pkg::s3_ctrl_t n_ctrl;

    // Handshake ----------------------------------------
    assign rng_valid = i_s2_valid && i_s2.fu == exec_pkg::FU_RNG;
    assign s3_hold   = o_s3_valid && i_s3_busy;         // Next stage full
    assign o_s2_busy = s3_hold || (rng_valid && !rng_ready);
    assign progress  = i_s2_valid && !o_s2_busy;

    // SLTU and unsigned branches share the compare
    assign cmp_unsigned =
        (i_s2.fu == exec_pkg::FU_ALU && i_s2.uop == exec_pkg::ALU_SLTU) ||
        (i_s2.fu == exec_pkg::FU_CFU && (i_s2.uop == exec_pkg::CFU_BLTU ||
                                         i_s2.uop == exec_pkg::CFU_BGEU));

    // Units --------------------------------------------
    exec_alu alu_i (
        .i_uop(i_s2.uop), .i_lhs(i_s2.opr_a), .i_rhs(i_s2.opr_b),
        .i_cmp_unsigned(cmp_unsigned), .o_result(alu_result),
        .o_add_result(add_result), .o_lt(lt), .o_eq(eq)
    );

    exec_rng_if rng_if_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_start(rng_valid), .i_progress(progress), .i_uop(i_s2.uop),
        .i_rs1(i_s2.opr_a), .o_rng_req(o_rng_req), .o_rng_req_valid(o_rng_req_valid),
        .i_rng_req_ready(i_rng_req_ready), .i_rng_rsp(i_rng_rsp),
        .i_rng_rsp_valid(i_rng_rsp_valid), .o_rng_rsp_ready(o_rng_rsp_ready),
        .o_result(rng_result), .o_ready(rng_ready)
    );

    exec_result_select result_select_i (
        .i_s2(i_s2), .i_alu_result(alu_result), .i_add_result(add_result),
        .i_lt(lt), .i_eq(eq), .i_rng_result(rng_result), .o_ctrl(n_ctrl),
        .o_opr_a(n_opr_a), .o_opr_b(n_opr_b), .o_opr_b_load(opr_b_load)
    );

    // Stage registers ----------------------------------
    exec_stage_reg #(.PAYLOAD_T(exec_pkg::s3_ctrl_t)) ctrl_reg_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush), .i_load(progress),
        .i_data(n_ctrl), .i_busy(s3_hold), .o_data(o_s3_ctrl), .o_valid(o_s3_valid)
    );

    exec_stage_reg #(.PAYLOAD_T(exec_pkg::xlen_t)) opr_a_reg_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush), .i_load(progress),
        .i_data(n_opr_a), .i_busy(s3_hold), .o_data(o_s3_opr_a), .o_valid()
    );

    // Operand B keeps its old value unless store, CSR or trap
    exec_stage_reg #(.PAYLOAD_T(exec_pkg::xlen_t)) opr_b_reg_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_load(progress && opr_b_load), .i_data(n_opr_b), .i_busy(s3_hold),
        .o_data(o_s3_opr_b), .o_valid()
    );

    // Issue side sends a known unit, and LSU ops are exactly load or store
    a_fu_known : assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid |-> i_s2.fu inside {exec_pkg::FU_ALU, exec_pkg::FU_LSU,
                       exec_pkg::FU_CFU, exec_pkg::FU_CSR, exec_pkg::FU_RNG});

    a_lsu_kind : assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid && i_s2.fu == exec_pkg::FU_LSU |->
        i_s2.uop[exec_pkg::LSU_LOAD_BIT] ^ i_s2.uop[exec_pkg::LSU_STORE_BIT]);

endmodule

//--- testbench/tb_exec_tasks.svh
/*
 * Directed tests and reference model for the execute stage testbench.
 * Included inside the testbench top, so the tasks drive its signals.
 */

// Reporting ----------------------------------------
task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    check_count++;
    assert (got === exp) else begin
        error_count++;
        $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
endtask

task automatic report_failure(input string what);
    error_count++;
    $display("** Error at %0t: %s", $time, what);
endtask

// Reference model ----------------------------------
function automatic logic signed_less(input xlen_t a, input xlen_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);          // Sign bits decide first
endfunction

function automatic xlen_t ref_alu(input exec_pkg::uop_t uop, input xlen_t a, input xlen_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (uop)
        exec_pkg::ALU_ADD:  return a + b;
        exec_pkg::ALU_SUB:  return a + ~b + 1;          // Two's complement
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_AND:  return a & b;
        exec_pkg::ALU_SLL:  return a << sh;
        exec_pkg::ALU_SRL:  return a >> sh;
        exec_pkg::ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        exec_pkg::ALU_SLT:  return xlen_t'(signed_less(a, b));
        exec_pkg::ALU_SLTU: return xlen_t'(a < b);
        default:            return '0;
    endcase
endfunction

function automatic logic ref_taken(input exec_pkg::uop_t uop, input xlen_t a, input xlen_t b);
    case (uop)
        exec_pkg::CFU_BEQ:  return a == b;
        exec_pkg::CFU_BNE:  return a != b;
        exec_pkg::CFU_BLT:  return signed_less(a, b);
        exec_pkg::CFU_BGE:  return !signed_less(a, b);
        exec_pkg::CFU_BLTU: return a < b;
        default:            return !(a < b);            // BGEU
    endcase
endfunction

function automatic s2_instr_t make_instr(input exec_pkg::fu_e fu, input exec_pkg::uop_t uop,
                                         input xlen_t a, input xlen_t b, input xlen_t c);
    s2_instr_t instr;
    instr       = '0;
    instr.rd    = c[4:0];
    instr.fu    = fu;
    instr.uop   = uop;
    instr.opr_a = a;
    instr.opr_b = b;
    instr.opr_c = c;
    instr.size  = 2'b10;                                // Full-size instruction
    return instr;
endfunction

// Handshake helpers --------------------------------
task automatic send_instr(input s2_instr_t instr);
    @(posedge g_clk);
    s2_instr <= instr;
    s2_valid <= 1'b1;
endtask

// For an RNG op busy has to drop exactly after the response handshake
task automatic wait_accept(input logic is_rng);
    int unsigned rsp_before;
    rsp_before = rsp_count;
    do begin
        @(negedge g_clk);
        if (is_rng)
            assert (s2_busy == (rsp_count == rsp_before))
                else report_failure("o_s2_busy does not follow the RNG response handshake");
    end while (s2_busy);
    @(posedge g_clk);                                   // Transfer edge
    s2_valid <= 1'b0;
endtask

task automatic wait_result(output s3_ctrl_t ctrl, output xlen_t opr_a, output xlen_t opr_b);
    int unsigned late;
    late = 0;
    @(negedge g_clk);
    while (!s3_valid) begin
        late++;
        @(negedge g_clk);
    end
    assert (late == 0) else report_failure("result reached s3 later than one cycle after issue");
    ctrl  = s3_ctrl;
    opr_a = s3_opr_a;
    opr_b = s3_opr_b;
endtask

task automatic run_instr(input s2_instr_t instr, output s3_ctrl_t ctrl,
                         output xlen_t opr_a, output xlen_t opr_b);
    send_instr(instr);
    wait_accept(instr.fu == exec_pkg::FU_RNG);
    wait_result(ctrl, opr_a, opr_b);
endtask

// Directed tests -----------------------------------
task automatic test_alu();
    exec_pkg::uop_t ops [10];
    s3_ctrl_t       ctrl;
    xlen_t          a, b, opr_a, opr_b;
    ops = '{exec_pkg::ALU_ADD, exec_pkg::ALU_SUB, exec_pkg::ALU_XOR, exec_pkg::ALU_OR,
            exec_pkg::ALU_AND, exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA,
            exec_pkg::ALU_SLT, exec_pkg::ALU_SLTU};
    foreach (ops[i]) begin
        repeat (4) begin
            a = $random(seed);
            b = $random(seed);
            run_instr(make_instr(exec_pkg::FU_ALU, ops[i], a, b, '0), ctrl, opr_a, opr_b);
            check_value("o_s3_opr_a", opr_a, ref_alu(ops[i], a, b));
        end
    end
endtask

task automatic test_branch();
    exec_pkg::uop_t conds [6];
    xlen_t          lhs [5];
    xlen_t          rhs [5];
    s3_ctrl_t       ctrl;
    xlen_t          a, b, c, opr_a, opr_b;
    conds = '{exec_pkg::CFU_BEQ, exec_pkg::CFU_BNE, exec_pkg::CFU_BLT,
              exec_pkg::CFU_BGE, exec_pkg::CFU_BLTU, exec_pkg::CFU_BGEU};
    lhs   = '{32'd5, 32'd2, 32'd9, 32'hffff_fffd, 32'd7};  // Last two flip with sign
    rhs   = '{32'd5, 32'd9, 32'd2, 32'd7, 32'hffff_fffd};
    foreach (conds[i]) begin
        foreach (lhs[j]) begin
            run_instr(make_instr(exec_pkg::FU_CFU, conds[i], lhs[j], rhs[j], 32'h100),
                      ctrl, opr_a, opr_b);
            check_value("o_s3_ctrl.uop", xlen_t'(ctrl.uop),
                        xlen_t'(ref_taken(conds[i], lhs[j], rhs[j]) ?
                                exec_pkg::CFU_TAKEN : exec_pkg::CFU_NOT_TAKEN));
        end
    end
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    run_instr(make_instr(exec_pkg::FU_CFU, exec_pkg::CFU_JALR, a, b, c), ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, (a + b) & ~32'h1);
    run_instr(make_instr(exec_pkg::FU_CFU, exec_pkg::CFU_JAL, a, b, c), ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, c & ~32'h1);
endtask

task automatic test_lsu_csr();
    s3_ctrl_t       ctrl;
    xlen_t          a, b, c, opr_a, opr_b;
    exec_pkg::uop_t load_op, store_op;
    a        = $random(seed);
    b        = $random(seed);
    c        = $random(seed);
    load_op  = exec_pkg::uop_t'(1 << exec_pkg::LSU_LOAD_BIT);
    store_op = exec_pkg::uop_t'(1 << exec_pkg::LSU_STORE_BIT);
    run_instr(make_instr(exec_pkg::FU_LSU, store_op, a, b, c), ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, a + b);
    check_value("o_s3_opr_b", opr_b, c);            // Store data
    run_instr(make_instr(exec_pkg::FU_LSU, load_op, a, b, ~c), ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, a + b);
    check_value("o_s3_opr_b", opr_b, c);            // Kept from the store
    run_instr(make_instr(exec_pkg::FU_CSR, 5'd1, a, b, c), ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, a);
    check_value("o_s3_opr_b", opr_b, c);
endtask

task automatic test_rng();
    exec_pkg::uop_t    uops [3];
    exec_pkg::rng_op_e ops [3];
    s3_ctrl_t          ctrl;
    xlen_t             a, opr_a, opr_b;
    uops = '{exec_pkg::RNG_TEST, exec_pkg::RNG_SEED, exec_pkg::RNG_SAMP};
    ops  = '{exec_pkg::RNG_OP_TEST, exec_pkg::RNG_OP_SEED, exec_pkg::RNG_OP_SAMP};
    foreach (uops[i]) begin
        a = $random(seed);
        run_instr(make_instr(exec_pkg::FU_RNG, uops[i], a, '0, '0), ctrl, opr_a, opr_b);
        check_value("o_rng_req.op", xlen_t'(seen_req.op), xlen_t'(ops[i]));
        check_value("o_rng_req.data", seen_req.data, a);
        check_value("o_s3_opr_a", opr_a, uops[i] == exec_pkg::RNG_SAMP ?
                    sent_rsp.data : xlen_t'(sent_rsp.status));
    end
endtask

task automatic test_backpressure_flush();
    s3_ctrl_t ctrl, exp_ctrl;
    xlen_t    a, b, opr_a, opr_b;
    a             = $random(seed);
    b             = $random(seed);
    exp_ctrl      = '0;                                 // rd 0, no trap
    exp_ctrl.fu   = exec_pkg::FU_ALU;
    exp_ctrl.uop  = exec_pkg::ALU_XOR;
    exp_ctrl.size = 2'b10;
    @(posedge g_clk);
    s3_busy <= 1'b1;
    run_instr(make_instr(exec_pkg::FU_ALU, exec_pkg::ALU_XOR, a, b, '0), ctrl, opr_a, opr_b);
    send_instr(make_instr(exec_pkg::FU_ALU, exec_pkg::ALU_ADD, a, b, '0));   // Waits behind
    repeat (5) begin
        @(negedge g_clk);
        assert (s3_valid && s2_busy) else report_failure("s3 did not hold under i_s3_busy");
        check_value("o_s3_opr_a", s3_opr_a, a ^ b);
        check_value("o_s3_ctrl", xlen_t'(s3_ctrl), xlen_t'(exp_ctrl));
    end
    @(posedge g_clk);
    s3_busy <= 1'b0;
    wait_accept(1'b0);
    wait_result(ctrl, opr_a, opr_b);
    check_value("o_s3_opr_a", opr_a, a + b);
    @(posedge g_clk);
    s3_busy <= 1'b1;
    run_instr(make_instr(exec_pkg::FU_ALU, exec_pkg::ALU_OR, a, b, '0), ctrl, opr_a, opr_b);
    @(posedge g_clk);
    flush <= 1'b1;
    @(posedge g_clk);
    flush   <= 1'b0;
    s3_busy <= 1'b0;
    @(negedge g_clk);
    assert (!s3_valid) else report_failure("flush did not clear o_s3_valid");
endtask

task automatic test_trap();
    s2_instr_t instr;
    s3_ctrl_t  ctrl;
    xlen_t     opr_a, opr_b;
    repeat (2) begin
        instr = make_instr(exec_pkg::FU_ALU, exec_pkg::ALU_ADD, $random(seed), $random(seed),
                           $random(seed));
        instr.trap = 1'b1;
        run_instr(instr, ctrl, opr_a, opr_b);
        check_value("o_s3_ctrl.trap", xlen_t'(ctrl.trap), 32'd1);
        check_value("o_s3_opr_b", opr_b, xlen_t'(instr.rd));   // Cause is rd
    end
endtask

//--- testbench/tb_exec_stage.sv
/*
 * Testbench top for the execute stage.
 * Gives clock, reset, an RNG responder with random delays and a cycle
 * watchdog. The directed tests and the reference model are included.
 */
`timescale 1ns/1ps

module tb_exec_stage;

    typedef exec_pkg::xlen_t     xlen_t;
    typedef exec_pkg::s2_instr_t s2_instr_t;
    typedef exec_pkg::s3_ctrl_t  s3_ctrl_t;

    localparam int unsigned RESET_CYCLES     = 10;
    localparam int unsigned INSTR_COUNT      = 83;      // 40 ALU, 32 CFU, 3 LSU/CSR, 3 RNG, 5 more
    localparam int unsigned CYCLES_PER_INSTR = 12;      // RNG worst case with both delays
    localparam int unsigned MAX_CYCLES = RESET_CYCLES + INSTR_COUNT * CYCLES_PER_INSTR + 40;

    logic               g_clk, g_resetn, flush;
    s2_instr_t          s2_instr;
    logic               s2_valid, s2_busy;
    exec_pkg::rng_req_t rng_req;
    logic               rng_req_valid, rng_req_ready;
    exec_pkg::rng_rsp_t rng_rsp;
    logic               rng_rsp_valid, rng_rsp_ready;
    s3_ctrl_t           s3_ctrl;
    xlen_t              s3_opr_a, s3_opr_b;
    logic               s3_valid, s3_busy;

    int                 seed        = 61236;
    int unsigned        check_count = 0;
    int unsigned        error_count = 0;
    int unsigned        rsp_count   = 0;                // Response handshakes so far
    int unsigned        cycle_count = 0;
    exec_pkg::rng_req_t seen_req;                       // Request as the RNG took it
    exec_pkg::rng_rsp_t sent_rsp;                       // Last response given

    exec_stage exec_stage_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(flush),
        .i_s2(s2_instr), .i_s2_valid(s2_valid), .o_s2_busy(s2_busy),
        .o_rng_req(rng_req), .o_rng_req_valid(rng_req_valid), .i_rng_req_ready(rng_req_ready),
        .i_rng_rsp(rng_rsp), .i_rng_rsp_valid(rng_rsp_valid), .o_rng_rsp_ready(rng_rsp_ready),
        .o_s3_ctrl(s3_ctrl), .o_s3_opr_a(s3_opr_a), .o_s3_opr_b(s3_opr_b),
        .o_s3_valid(s3_valid), .i_s3_busy(s3_busy)
    );

    `include "tb_exec_tasks.svh"

    initial begin : clock_gen
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;                     // 40 ns period
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge g_clk);
            cycle_count++;
        end
        $display("** Error: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // RNG responder ------------------------------------
    initial begin : rng_responder
        int unsigned delay;
        forever begin
            @(negedge g_clk);
            if (rng_req_valid) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge g_clk);
                seen_req = rng_req;                     // Stable until taken
                @(posedge g_clk);
                rng_req_ready <= 1'b1;
                @(posedge g_clk);                       // Request handshake
                rng_req_ready <= 1'b0;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge g_clk);
                sent_rsp.status = exec_pkg::rng_status_t'($random(seed));
                sent_rsp.data   = $random(seed);
                rng_rsp       <= sent_rsp;
                rng_rsp_valid <= 1'b1;
                @(negedge g_clk);
                assert (rng_rsp_ready)
                    else report_failure("o_rng_rsp_ready is low while a response waits");
                @(posedge g_clk);                       // Response handshake
                rng_rsp_valid <= 1'b0;
                rsp_count++;
            end
        end
    end

    initial begin : main
        g_resetn      = 1'b0;
        flush         = 1'b0;
        s2_instr      = '0;
        s2_valid      = 1'b0;
        s3_busy       = 1'b0;
        rng_req_ready = 1'b0;
        rng_rsp       = '0;
        rng_rsp_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        assert (!s3_valid && !rng_req_valid && !rng_rsp_ready)
            else report_failure("o_s3_valid, o_rng_req_valid or o_rng_rsp_ready high after reset");
        test_alu();
        test_branch();
        test_lsu_csr();
        test_rng();
        test_backpressure_flush();
        test_trap();
        repeat (2) @(posedge g_clk);
        $display("Value checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- exec_stage.f
+incdir+testbench
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_result_select.sv
hdl/exec_rng_if.sv
hdl/exec_stage_reg.sv
hdl/exec_stage.sv
testbench/tb_exec_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= exec_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
